//--- src.f
+incdir+verif
rtl/uart_pkg.sv
rtl/uart_csr_pkg.sv
rtl/uart_baud_gen.sv
rtl/uart_xmit.sv
rtl/uart_rcv.sv
rtl/uart_csr.sv
rtl/uart_top.sv
verif/uart_tb.sv

//--- Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build uart_tb with Verilator, run it and search the log for the pass line"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal -f src.f --top-module uart_tb -Mdir obj_dir
	./obj_dir/Vuart_tb | tee $(LOG)
	grep -qF "** PASS **" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- verif/uart_tb_tasks.svh
`ifndef UART_TB_TASKS_SVH
`define UART_TB_TASKS_SVH

task automatic fail_stop(input string why);
  $display("%s", why);
  $display("** FAIL **");
  $fatal(1, "Simulation stopped on the first error");
endtask

task automatic check_data(input string name, input data_t got, input data_t exp);
  if (got !== exp) begin
    fail_stop($sformatf("ERR t=%0t %s: got %h, expected %h", $time, name, got, exp));
  end
endtask

task automatic check_reg(input string name, input reg_t got, input reg_t exp);
  if (got !== exp) begin
    fail_stop($sformatf("ERR t=%0t %s: got %h, expected %h", $time, name, got, exp));
  end
endtask

task automatic check_resp(input string name, input resp_t got, input resp_t exp);
  if (got !== exp) begin
    fail_stop($sformatf("ERR t=%0t %s: got %h, expected %h", $time, name, got, exp));
  end
endtask

// Line order of an 8N1 frame, index 0 leaves first
function automatic logic [9:0] expected_frame(input data_t b);
  return {1'b1, b, 1'b0};
endfunction

// Galois form with taps for a maximal 16-bit sequence
function automatic logic [15:0] lfsr_step(input logic [15:0] s);
  logic [15:0] n;
  n = s >> 1;
  if (s[0]) begin
    n = n ^ 16'hB400;
  end
  return n;
endfunction

task automatic next_byte(output data_t b);
  b = '0;
  for (int i = 0; i < 8; i++) begin
    lfsr = lfsr_step(lfsr);
    b = {b[6:0], lfsr[0]};
  end
endtask

task automatic axi_write(input addr_t addr, input reg_t data, output resp_t resp);
  @(posedge sys_clk);
  awaddr  <= addr;
  awvalid <= 1'b1;
  wdata   <= data;
  wvalid  <= 1'b1;
  bready  <= 1'b1;
  do begin
    @(posedge sys_clk);
  end while (!(awready && wready));
  awvalid <= 1'b0;
  wvalid  <= 1'b0;
  do begin
    @(posedge sys_clk);
  end while (!bvalid);
  resp = bresp;
  bready <= 1'b0;
endtask

task automatic axi_read(input addr_t addr, output reg_t data, output resp_t resp);
  @(posedge sys_clk);
  araddr  <= addr;
  arvalid <= 1'b1;
  rready  <= 1'b1;
  do begin
    @(posedge sys_clk);
  end while (!arready);
  arvalid <= 1'b0;
  do begin
    @(posedge sys_clk);
  end while (!rvalid);
  data = rdata;
  resp = rresp;
  rready <= 1'b0;
endtask

// Called right after the falling start edge, samples each bit near its middle
task automatic sample_frame(output logic [9:0] frame);
  repeat (8 * cur_div) @(negedge sys_clk);
  frame[0] = txd;
  for (int i = 1; i < 10; i++) begin
    repeat (16 * cur_div) @(negedge sys_clk);
    frame[i] = txd;
  end
endtask

task automatic send_frame(input data_t b, input logic stop_level);
  logic [9:0] bits;
  bits = expected_frame(b);
  bits[9] = stop_level;
  for (int i = 0; i < 10; i++) begin
    @(posedge sys_clk);
    rxd <= bits[i];
    repeat (16 * cur_div - 1) @(posedge sys_clk);
  end
  // One idle bit time before anything else happens on the line
  @(posedge sys_clk);
  rxd <= 1'b1;
  repeat (16 * cur_div - 1) @(posedge sys_clk);
endtask

`endif

//--- verif/uart_tb.sv
`default_nettype none

module uart_tb
  import uart_pkg::*;
  import uart_csr_pkg::*;
();

  localparam div_t DIV_START = 16'd4;
  localparam div_t DIV_SLOW  = 16'd7;
  localparam int   N_BYTES   = 4;

  // Two batches each way, plus busy test, its quiet wait, overrun pair and bad frame
  localparam int N_FRAMES    = 4 * N_BYTES + 5;
  localparam int CYCLE_LIMIT = N_FRAMES * 16 * int'(DIV_SLOW) * 12 + 5000;

  localparam reg_t ST_TX_BUSY   = 32'h1;
  localparam reg_t ST_RX_VALID  = 32'h2;
  localparam reg_t ST_OVERRUN   = 32'h4;
  localparam reg_t ST_FRAME_ERR = 32'h8;

  logic  sys_clk;
  logic  sys_rst_l;
  addr_t awaddr;
  logic  awvalid;
  logic  awready;
  reg_t  wdata;
  logic  wvalid;
  logic  wready;
  resp_t bresp;
  logic  bvalid;
  logic  bready;
  addr_t araddr;
  logic  arvalid;
  logic  arready;
  reg_t  rdata;
  resp_t rresp;
  logic  rvalid;
  logic  rready;
  logic  txd;
  logic  rxd;

  int          cur_div;
  int          cycles;
  int          tx_count;
  int          frames_seen;
  logic [15:0] lfsr;
  data_t       exp_q[$];

  uart_top #(
    .DIV_RESET (DIV_START)
  ) uart_top_inst (
    .sys_clk   (sys_clk),
    .sys_rst_l (sys_rst_l),
    .awaddr    (awaddr),
    .awvalid   (awvalid),
    .awready   (awready),
    .wdata     (wdata),
    .wvalid    (wvalid),
    .wready    (wready),
    .bresp     (bresp),
    .bvalid    (bvalid),
    .bready    (bready),
    .araddr    (araddr),
    .arvalid   (arvalid),
    .arready   (arready),
    .rdata     (rdata),
    .rresp     (rresp),
    .rvalid    (rvalid),
    .rready    (rready),
    .txd       (txd),
    .rxd       (rxd)
  );

  `include "uart_tb_tasks.svh"

  task automatic read_expect(input addr_t addr, input reg_t exp, input string name);
    reg_t  word;
    resp_t r;
    axi_read(addr, word, r);
    check_resp("rresp", r, RESP_OKAY);
    check_reg(name, word, exp);
  endtask

  task automatic read_rx_byte(input data_t exp);
    reg_t  word;
    resp_t r;
    axi_read(ADDR_RXDATA, word, r);
    check_resp("rresp", r, RESP_OKAY);
    check_data("RXDATA", word[7:0], exp);
  endtask

  task automatic poll_status(input reg_t mask, input reg_t value);
    reg_t  word;
    resp_t r;
    do begin
      axi_read(ADDR_STATUS, word, r);
    end while ((word & mask) != value);
  endtask

  // The byte is queued first so the checker already holds it when the start bit falls
  task automatic send_byte(input data_t b);
    resp_t r;
    exp_q.push_back(b);
    tx_count++;
    axi_write(ADDR_TXDATA, reg_t'(b), r);
    check_resp("bresp", r, RESP_OKAY);
  endtask

  task automatic wait_tx_done();
    while (frames_seen != tx_count) begin
      @(posedge sys_clk);
    end
  endtask

  task automatic run_tx_batch();
    data_t b;
    for (int i = 0; i < N_BYTES; i++) begin
      next_byte(b);
      send_byte(b);
      read_expect(ADDR_STATUS, ST_TX_BUSY, "STATUS");
      wait_tx_done();
      poll_status(ST_TX_BUSY, '0);
      read_expect(ADDR_STATUS, '0, "STATUS");
    end
  endtask

  task automatic run_rx_batch();
    data_t b;
    for (int i = 0; i < N_BYTES; i++) begin
      next_byte(b);
      send_frame(b, 1'b1);
      poll_status(ST_RX_VALID, ST_RX_VALID);
      read_expect(ADDR_STATUS, ST_RX_VALID, "STATUS");
      read_rx_byte(b);
      read_expect(ADDR_STATUS, '0, "STATUS");
    end
  endtask

  always #50 sys_clk = ~sys_clk;

  always @(posedge sys_clk) begin
    cycles <= cycles + 1;
    if (cycles > CYCLE_LIMIT) begin
      fail_stop("Timeout: the test did not finish within its cycle limit");
    end
  end

  // Every frame on txd must match the oldest byte still waiting in the queue
  initial begin : txd_checker
    logic [9:0] frame;
    data_t      byte_exp;
    forever begin
      @(negedge txd);
      if (exp_q.size() == 0) begin
        fail_stop("A frame appeared on txd although no byte was waiting to be sent");
      end
      byte_exp = exp_q.pop_front();
      sample_frame(frame);
      check_reg("txd frame", reg_t'(frame), reg_t'(expected_frame(byte_exp)));
      frames_seen++;
    end
  end

  initial begin : main_seq
    reg_t  word;
    resp_t r;
    data_t b_first;
    data_t b_second;
    sys_clk     = 1'b0;
    sys_rst_l   = 1'b0;
    awaddr      = '0;
    awvalid     = 1'b0;
    wdata       = '0;
    wvalid      = 1'b0;
    bready      = 1'b0;
    araddr      = '0;
    arvalid     = 1'b0;
    rready      = 1'b0;
    rxd         = 1'b1;
    cur_div     = int'(DIV_START);
    cycles      = 0;
    tx_count    = 0;
    frames_seen = 0;
    lfsr        = 16'd4;
    repeat (10) @(posedge sys_clk);
    sys_rst_l <= 1'b1;
    @(posedge sys_clk);

    check_reg("txd", reg_t'(txd), 32'h1);
    read_expect(ADDR_STATUS, '0, "STATUS");
    read_expect(ADDR_DIVISOR, reg_t'(DIV_START), "DIVISOR");
    // Write-only and unmapped offsets both answer with an error
    axi_read(ADDR_TXDATA, word, r);
    check_resp("rresp", r, RESP_SLVERR);
    axi_read(4'h2, word, r);
    check_resp("rresp", r, RESP_SLVERR);
    axi_write(ADDR_STATUS, 32'hF, r);
    check_resp("bresp", r, RESP_SLVERR);
    read_expect(ADDR_STATUS, '0, "STATUS");

    run_tx_batch();

    next_byte(b_first);
    next_byte(b_second);
    send_byte(b_first);
    axi_write(ADDR_TXDATA, reg_t'(b_second), r);
    check_resp("bresp", r, RESP_SLVERR);
    wait_tx_done();
    poll_status(ST_TX_BUSY, '0);
    // Long enough for a stray second frame to reach the checker
    repeat (16 * cur_div * 12) @(posedge sys_clk);

    run_rx_batch();

    next_byte(b_first);
    next_byte(b_second);
    send_frame(b_first, 1'b1);
    send_frame(b_second, 1'b1);
    poll_status(ST_OVERRUN, ST_OVERRUN);
    read_expect(ADDR_STATUS, ST_RX_VALID | ST_OVERRUN, "STATUS");
    read_rx_byte(b_first);
    read_expect(ADDR_STATUS, '0, "STATUS");

    next_byte(b_second);
    send_frame(b_second, 1'b0);
    poll_status(ST_FRAME_ERR, ST_FRAME_ERR);
    read_expect(ADDR_STATUS, ST_FRAME_ERR, "STATUS");
    // The bad byte is dropped and RXDATA still holds the last good one
    read_rx_byte(b_first);
    read_expect(ADDR_STATUS, '0, "STATUS");

    axi_write(ADDR_DIVISOR, reg_t'(DIV_SLOW), r);
    check_resp("bresp", r, RESP_OKAY);
    cur_div = int'(DIV_SLOW);
    read_expect(ADDR_DIVISOR, reg_t'(DIV_SLOW), "DIVISOR");
    run_tx_batch();
    run_rx_batch();

    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire

//--- rtl/uart_top.sv
`default_nettype none

module uart_top
  import uart_pkg::*;
  import uart_csr_pkg::*;
#(
  parameter div_t DIV_RESET = 16'd4
) (
  input  logic  sys_clk,
  input  logic  sys_rst_l,
  input  addr_t awaddr,
  input  logic  awvalid,
  output logic  awready,
  input  reg_t  wdata,
  input  logic  wvalid,
  output logic  wready,
  output resp_t bresp,
  output logic  bvalid,
  input  logic  bready,
  input  addr_t araddr,
  input  logic  arvalid,
  output logic  arready,
  output reg_t  rdata,
  output resp_t rresp,
  output logic  rvalid,
  input  logic  rready,
  output logic  txd,
  input  logic  rxd
);

  logic  tick;
  logic  tx_start;
  logic  tx_busy;
  logic  rx_strobe;
  logic  rx_frame_err;
  data_t tx_data;
  data_t rx_data;
  div_t  div;

  uart_csr #(
    .DIV_RESET (DIV_RESET)
  ) uart_csr_inst (
    .sys_clk      (sys_clk),
    .sys_rst_l    (sys_rst_l),
    .awaddr       (awaddr),
    .awvalid      (awvalid),
    .awready      (awready),
    .wdata        (wdata),
    .wvalid       (wvalid),
    .wready       (wready),
    .bresp        (bresp),
    .bvalid       (bvalid),
    .bready       (bready),
    .araddr       (araddr),
    .arvalid      (arvalid),
    .arready      (arready),
    .rdata        (rdata),
    .rresp        (rresp),
    .rvalid       (rvalid),
    .rready       (rready),
    .tx_start     (tx_start),
    .tx_data      (tx_data),
    .tx_busy      (tx_busy),
    .rx_data      (rx_data),
    .rx_strobe    (rx_strobe),
    .rx_frame_err (rx_frame_err),
    .div          (div)
  );

  uart_baud_gen uart_baud_gen_inst (
    .sys_clk   (sys_clk),
    .sys_rst_l (sys_rst_l),
    .div       (div),
    .tick      (tick)
  );

  uart_xmit uart_xmit_inst (
    .sys_clk   (sys_clk),
    .sys_rst_l (sys_rst_l),
    .tick      (tick),
    .tx_start  (tx_start),
    .tx_data   (tx_data),
    .txd       (txd),
    .tx_busy   (tx_busy)
  );

  uart_rcv uart_rcv_inst (
    .sys_clk      (sys_clk),
    .sys_rst_l    (sys_rst_l),
    .tick         (tick),
    .rxd          (rxd),
    .rx_data      (rx_data),
    .rx_strobe    (rx_strobe),
    .rx_frame_err (rx_frame_err)
  );

endmodule

`default_nettype wire

//--- rtl/uart_csr.sv
`default_nettype none

module uart_csr
  import uart_pkg::*;
  import uart_csr_pkg::*;
#(
  parameter div_t DIV_RESET = 16'd4
) (
  input  logic  sys_clk,
  input  logic  sys_rst_l,
  input  addr_t awaddr,
  input  logic  awvalid,
  output logic  awready,
  input  reg_t  wdata,
  input  logic  wvalid,
  output logic  wready,
  output resp_t bresp,
  output logic  bvalid,
  input  logic  bready,
  input  addr_t araddr,
  input  logic  arvalid,
  output logic  arready,
  output reg_t  rdata,
  output resp_t rresp,
  output logic  rvalid,
  input  logic  rready,
  output logic  tx_start,
  output data_t tx_data,
  input  logic  tx_busy,
  input  data_t rx_data,
  input  logic  rx_strobe,
  input  logic  rx_frame_err,
  output div_t  div
);

  logic  wr_acc;
  logic  rd_acc;
  logic  wr_ok;
  logic  rd_ok;
  logic  rd_rxdata;
  logic  rx_load;
  logic  rx_valid;
  logic  overrun;
  logic  frame_err;
  data_t rx_hold;
  reg_t  rd_word;

  assign wr_acc    = awready && awvalid && wready && wvalid;
  assign rd_acc    = arready && arvalid;
  assign rd_rxdata = rd_acc && (araddr == ADDR_RXDATA);

  // A byte read out in this same cycle frees the holding register
  assign rx_load = rx_strobe && !rx_frame_err && !(rx_valid && !rd_rxdata);

  always_comb begin
    case (awaddr)
      ADDR_TXDATA:  wr_ok = !tx_busy && !tx_start;
      ADDR_DIVISOR: wr_ok = 1'b1;
      default:      wr_ok = 1'b0;
    endcase
  end

  always_comb begin
    rd_ok   = 1'b1;
    rd_word = '0;
    case (araddr)
      ADDR_RXDATA:  rd_word = reg_t'(rx_hold);
      ADDR_STATUS:  rd_word = reg_t'({frame_err, overrun, rx_valid, tx_busy});
      ADDR_DIVISOR: rd_word = reg_t'(div);
      default:      rd_ok   = 1'b0;
    endcase
  end

  always_ff @(posedge sys_clk or negedge sys_rst_l) begin
    if (!sys_rst_l) begin
      awready   <= 1'b0;
      wready    <= 1'b0;
      bvalid    <= 1'b0;
      arready   <= 1'b0;
      rvalid    <= 1'b0;
      tx_start  <= 1'b0;
      div       <= DIV_RESET;
      rx_valid  <= 1'b0;
      overrun   <= 1'b0;
      frame_err <= 1'b0;
    end else begin
      // Both ready lines pulse together and wait out a pending response
      awready  <= awvalid && wvalid && !bvalid && !awready;
      wready   <= awvalid && wvalid && !bvalid && !awready;
      arready  <= arvalid && !rvalid && !arready;
      tx_start <= 1'b0;

      if (wr_acc) begin
        bvalid <= 1'b1;
      end else if (bready) begin
        bvalid <= 1'b0;
      end

      if (rd_acc) begin
        rvalid <= 1'b1;
      end else if (rready) begin
        rvalid <= 1'b0;
      end

      if (wr_acc && wr_ok) begin
        if (awaddr == ADDR_TXDATA) begin
          tx_start <= 1'b1;
        end else begin
          div <= wdata[15:0];
        end
      end

      if (rd_rxdata) begin
        rx_valid  <= 1'b0;
        overrun   <= 1'b0;
        frame_err <= 1'b0;
      end

      if (rx_strobe) begin
        if (rx_frame_err) begin
          frame_err <= 1'b1;
        end else if (rx_load) begin
          rx_valid <= 1'b1;
        end else begin
          overrun <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge sys_clk) begin
    if (wr_acc) begin
      bresp <= wr_ok ? RESP_OKAY : RESP_SLVERR;
    end
    if (wr_acc && wr_ok && awaddr == ADDR_TXDATA) begin
      tx_data <= wdata[7:0];
    end
    if (rd_acc) begin
      rdata <= rd_word;
      rresp <= rd_ok ? RESP_OKAY : RESP_SLVERR;
    end
    if (rx_load) begin
      rx_hold <= rx_data;
    end
  end

endmodule

`default_nettype wire

//--- rtl/uart_rcv.sv
`default_nettype none

module uart_rcv
  import uart_pkg::*;
(
  input  logic  sys_clk,
  input  logic  sys_rst_l,
  input  logic  tick,
  input  logic  rxd,
  output data_t rx_data,
  output logic  rx_strobe,
  output logic  rx_frame_err
);

  rcv_state_t state;
  tick_cnt_t  tick_cnt;
  bit_cnt_t   bit_cnt;
  data_t      shift_reg;
  logic       rxd_meta;
  logic       rxd_sync;
  logic       cell_last;

  assign cell_last = tick && (tick_cnt == TICK_LAST);
  assign rx_data   = shift_reg;

  // The line idles high, so the synchronizer resets to 1
  always_ff @(posedge sys_clk or negedge sys_rst_l) begin
    if (!sys_rst_l) begin
      rxd_meta <= 1'b1;
      rxd_sync <= 1'b1;
    end else begin
      rxd_meta <= rxd;
      rxd_sync <= rxd_meta;
    end
  end

  always_ff @(posedge sys_clk or negedge sys_rst_l) begin
    if (!sys_rst_l) begin
      state        <= r_idle;
      tick_cnt     <= '0;
      bit_cnt      <= '0;
      rx_strobe    <= 1'b0;
      rx_frame_err <= 1'b0;
    end else begin
      rx_strobe <= 1'b0;
      case (state)
        r_idle: begin
          tick_cnt <= '0;
          bit_cnt  <= '0;
          if (tick && !rxd_sync) begin
            state <= r_start;
          end
        end

        // Confirm the start bit at its middle, otherwise it was a glitch
        r_start: begin
          if (tick) begin
            if (tick_cnt == TICK_MID) begin
              tick_cnt <= '0;
              state    <= rxd_sync ? r_idle : r_data;
            end else begin
              tick_cnt <= tick_cnt + 1'b1;
            end
          end
        end

        r_data: begin
          if (tick) begin
            tick_cnt <= tick_cnt + 1'b1;
          end
          if (cell_last) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == LAST_BIT) begin
              state <= r_stop;
            end
          end
        end

        r_stop: begin
          if (tick) begin
            tick_cnt <= tick_cnt + 1'b1;
          end
          if (cell_last) begin
            rx_strobe    <= 1'b1;
            rx_frame_err <= !rxd_sync;
            state        <= r_idle;
          end
        end

        default: begin
          state <= r_idle;
        end
      endcase
    end
  end

  always_ff @(posedge sys_clk) begin
    if (state == r_data && cell_last) begin
      shift_reg <= {rxd_sync, shift_reg[7:1]};
    end
  end

endmodule

`default_nettype wire

//--- rtl/uart_xmit.sv
`default_nettype none

module uart_xmit
  import uart_pkg::*;
(
  input  logic  sys_clk,
  input  logic  sys_rst_l,
  input  logic  tick,
  input  logic  tx_start,
  input  data_t tx_data,
  output logic  txd,
  output logic  tx_busy
);

  xmit_state_t state;
  tick_cnt_t   tick_cnt;
  bit_cnt_t    bit_cnt;
  data_t       shift_reg;
  logic        cell_first;
  logic        cell_last;

  // A cell begins on the tick with count 0 and ends on the tick with count 15
  assign cell_first = tick && (tick_cnt == '0);
  assign cell_last  = tick && (tick_cnt == TICK_LAST);

  always_ff @(posedge sys_clk or negedge sys_rst_l) begin
    if (!sys_rst_l) begin
      state    <= x_idle;
      tick_cnt <= '0;
      bit_cnt  <= '0;
      txd      <= 1'b1;
      tx_busy  <= 1'b0;
    end else begin
      case (state)
        x_idle: begin
          tick_cnt <= '0;
          bit_cnt  <= '0;
          if (tx_start) begin
            state   <= x_start;
            tx_busy <= 1'b1;
          end
        end

        x_start: begin
          if (cell_first) begin
            txd <= 1'b0;
          end
          if (tick) begin
            tick_cnt <= tick_cnt + 1'b1;
          end
          if (cell_last) begin
            state <= x_data;
          end
        end

        x_data: begin
          if (cell_first) begin
            txd <= shift_reg[0];
          end
          if (tick) begin
            tick_cnt <= tick_cnt + 1'b1;
          end
          if (cell_last) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == LAST_BIT) begin
              state <= x_stop;
            end
          end
        end

        x_stop: begin
          if (cell_first) begin
            txd <= 1'b1;
          end
          if (tick) begin
            tick_cnt <= tick_cnt + 1'b1;
          end
          // The next start bit can only begin a full cell after this one did
          if (cell_last) begin
            state   <= x_idle;
            tx_busy <= 1'b0;
          end
        end

        default: begin
          state <= x_idle;
        end
      endcase
    end
  end

  // Data leaves LSB first, one shift at the start of each data cell
  always_ff @(posedge sys_clk) begin
    if (state == x_idle && tx_start) begin
      shift_reg <= tx_data;
    end else if (state == x_data && cell_first) begin
      shift_reg <= shift_reg >> 1;
    end
  end

endmodule

`default_nettype wire

//--- rtl/uart_baud_gen.sv
`default_nettype none

module uart_baud_gen
  import uart_pkg::*;
(
  input  logic sys_clk,
  input  logic sys_rst_l,
  input  div_t div,
  output logic tick
);

  div_t cnt;
  div_t div_eff;

  // A divisor of 0 behaves like 1 so the tick never stalls
  assign div_eff = (div == '0) ? div_t'(1) : div;

  always_ff @(posedge sys_clk or negedge sys_rst_l) begin
    if (!sys_rst_l) begin
      cnt  <= '0;
      tick <= 1'b0;
    end else if (cnt == '0) begin
      cnt  <= div_eff - 1'b1;
      tick <= 1'b1;
    end else begin
      cnt  <= cnt - 1'b1;
      tick <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- rtl/uart_csr_pkg.sv
`default_nettype none

package uart_csr_pkg;

  // Register byte address on the AXI4-Lite port
  typedef logic [3:0] addr_t;

  // One register word
  typedef logic [31:0] reg_t;

  // AXI response code
  typedef logic [1:0] resp_t;

  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

  // Write only, starts a transmit
  localparam addr_t ADDR_TXDATA  = 4'h0;

  // Read only, a read clears rx_valid, overrun and frame_err
  localparam addr_t ADDR_RXDATA  = 4'h4;

  // Read only, {frame_err, overrun, rx_valid, tx_busy} in bits 3:0
  localparam addr_t ADDR_STATUS  = 4'h8;

  // Read and write, lower 16 bits hold the baud divisor
  localparam addr_t ADDR_DIVISOR = 4'hC;

endpackage

`default_nettype wire

//--- rtl/uart_pkg.sv
`default_nettype none

package uart_pkg;

  // One serial character
  typedef logic [7:0] data_t;

  // Position inside a bit cell of 16 oversample ticks
  typedef logic [3:0] tick_cnt_t;

  // Data bit index within a frame
  typedef logic [3:0] bit_cnt_t;

  // Baud divisor in sys_clk cycles per oversample tick
  typedef logic [15:0] div_t;

  localparam tick_cnt_t TICK_LAST = 4'd15;
  localparam tick_cnt_t TICK_MID  = 4'd7;
  localparam bit_cnt_t  LAST_BIT  = 4'd7;

  typedef enum logic [1:0] {
    x_idle,
    x_start,
    x_data,
    x_stop
  } xmit_state_t;

  typedef enum logic [1:0] {
    r_idle,
    r_start,
    r_data,
    r_stop
  } rcv_state_t;

endpackage

`default_nettype wire
